// ==== src/mem_pkg.sv ====
package mem_pkg;

  // ####################
  // Widths
  // ####################

  // One data word and one byte address of the 32-bit core
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // Destination register number in the integer register file
  typedef logic [4:0] reg_addr_t;

  // One enable bit per byte lane of a word
  typedef logic [3:0] strobe_t;

  // ####################
  // Exceptions
  // ####################

  // Values follow the mcause encoding of the privileged spec
  typedef logic [3:0] cause_t;

  localparam cause_t CAUSE_LOAD_MISALIGNED = 4'd4;
  localparam cause_t CAUSE_STORE_MISALIGNED = 4'd6;

  // ####################
  // Operations
  // ####################

  typedef enum logic [3:0] {
    LSU_NONE,
    LSU_LB,
    LSU_LH,
    LSU_LW,
    LSU_LBU,
    LSU_LHU,
    LSU_SB,
    LSU_SH,
    LSU_SW
  } lsu_op_t;

  // States of the memory stage sequencer
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    HOLD
  } ctrl_state_t;

endpackage

// ==== src/store_align.sv ====
module store_align import mem_pkg::*; (
  input  lsu_op_t op,
  input  addr_t   addr,
  input  word_t   sdata,
  output word_t   wdata,
  output strobe_t wstrb,
  output logic    misaligned
);

  // Byte offset inside the addressed word
  logic [1:0] offset;

  assign offset = addr[1:0];

  always_comb begin
    wdata = sdata;
    wstrb = '0;
    misaligned = 1'b0;
    case (op)
      LSU_SB: begin
        // The byte is copied to every lane, the strobe picks the one written
        wdata = {4{sdata[7:0]}};
        wstrb = strobe_t'(4'b0001 << offset);
      end
      LSU_SH: begin
        wdata = {2{sdata[15:0]}};
        wstrb = offset[1] ? 4'b1100 : 4'b0011;
        misaligned = offset[0];
      end
      LSU_SW: begin
        wstrb = 4'b1111;
        misaligned = (offset != 2'b00);
      end
      default: begin
        wstrb = '0;
      end
    endcase

    // A misaligned store must never touch memory
    if (misaligned) begin
      wstrb = '0;
    end
  end

endmodule

// ==== src/load_align.sv ====
module load_align import mem_pkg::*; (
  input  lsu_op_t op,
  input  addr_t   addr,
  input  word_t   rdata,
  output word_t   result,
  output logic    misaligned
);

  logic [1:0]  offset;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  assign offset = addr[1:0];

  // ####################
  // Lane selection
  // ####################

  assign byte_sel = rdata[8 * offset +: 8];
  assign half_sel = offset[1] ? rdata[31:16] : rdata[15:0];

  // ####################
  // Extension
  // ####################

  always_comb begin
    result = rdata;
    misaligned = 1'b0;
    case (op)
      LSU_LB: begin
        result = {{24{byte_sel[7]}}, byte_sel};
      end
      LSU_LBU: begin
        result = {24'b0, byte_sel};
      end
      LSU_LH: begin
        result = {{16{half_sel[15]}}, half_sel};
        misaligned = offset[0];
      end
      LSU_LHU: begin
        result = {16'b0, half_sel};
        misaligned = offset[0];
      end
      LSU_LW: begin
        result = rdata;
        misaligned = (offset != 2'b00);
      end
      default: begin
        // Stores and pass-through ops never use this result
        result = rdata;
      end
    endcase
  end

endmodule

// ==== src/data_tim.sv ====
module data_tim import mem_pkg::*; #(
  parameter int DEPTH_WORDS = 256,
  parameter int WAIT_STATES = 2
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    mem_valid,
  input  addr_t   mem_addr,
  input  word_t   mem_wdata,
  input  strobe_t mem_wstrb,
  output logic    mem_ready,
  output word_t   mem_rdata
);

  localparam int INDEX_BITS = $clog2(DEPTH_WORDS);

  // The response is registered, so zero wait states behaves like one
  localparam int LAST_COUNT = (WAIT_STATES > 0) ? WAIT_STATES - 1 : 0;
  localparam int COUNT_BITS = $clog2(LAST_COUNT + 2);

  word_t mem [DEPTH_WORDS];

  logic [INDEX_BITS-1:0] index;
  logic [COUNT_BITS-1:0] wait_count;
  logic                  expire;

  assign index = mem_addr[INDEX_BITS+1:2];

  // The request is answered once, on the cycle the counter runs out
  assign expire = mem_valid && !mem_ready && (wait_count == COUNT_BITS'(LAST_COUNT));

  // ####################
  // Wait counter
  // ####################

  always_ff @(posedge clock) begin
    if (!reset) begin
      wait_count <= '0;
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= expire;
      if (expire || mem_ready || !mem_valid) begin
        wait_count <= '0;
      end else begin
        wait_count <= wait_count + 1'b1;
      end
    end
  end

  // ####################
  // Storage
  // ####################

  always_ff @(posedge clock) begin
    if (expire) begin
      mem_rdata <= mem[index];
      for (int lane = 0; lane < 4; lane++) begin
        if (mem_wstrb[lane]) begin
          mem[index][8 * lane +: 8] <= mem_wdata[8 * lane +: 8];
        end
      end
    end
  end

endmodule

// ==== src/memory_control.sv ====
module memory_control import mem_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      clear,
  input  logic      in_valid,
  output logic      in_ready,
  input  lsu_op_t   in_op,
  input  addr_t     in_addr,
  input  word_t     in_sdata,
  input  word_t     in_wdata,
  input  reg_addr_t in_waddr,
  input  logic      in_wren,
  input  addr_t     in_pc,
  output logic      out_valid,
  input  logic      out_ready,
  output logic      out_wren,
  output reg_addr_t out_waddr,
  output word_t     out_wdata,
  output logic      out_exception,
  output cause_t    out_ecause,
  output addr_t     out_etval,
  output addr_t     out_pc,
  output logic      mem_valid,
  input  logic      mem_ready,
  output addr_t     mem_addr,
  output word_t     mem_wdata,
  output strobe_t   mem_wstrb,
  output lsu_op_t   op,
  output addr_t     op_addr,
  output word_t     op_sdata,
  input  word_t     st_wdata,
  input  strobe_t   st_wstrb,
  input  logic      st_misaligned,
  input  word_t     ld_result,
  input  logic      ld_misaligned
);

  ctrl_state_t state;
  ctrl_state_t state_next;

  lsu_op_t op_q;
  addr_t   addr_q;

  logic accept;
  logic issue;
  logic misaligned;
  logic complete;
  logic squash;
  logic op_is_load;

  // ####################
  // Handshake
  // ####################

  // A held result may leave on the same edge a new instruction enters
  assign in_ready = !clear && ((state == IDLE) || ((state == HOLD) && out_ready));
  assign accept = in_valid && in_ready;
  assign out_valid = (state == HOLD);

  // The aligners see the incoming instruction while it is being accepted
  assign op = accept ? in_op : op_q;
  assign op_addr = accept ? in_addr : addr_q;
  assign op_sdata = in_sdata;

  assign misaligned = st_misaligned || ld_misaligned;
  assign issue = (in_op != LSU_NONE) && !misaligned;
  assign complete = (state == ACCESS) && mem_ready;
  assign op_is_load = op_q inside {LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU};

  // ####################
  // State machine
  // ####################

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (accept) begin
          state_next = issue ? ACCESS : HOLD;
        end
      end
      ACCESS: begin
        // A flushed access still runs to its end, its result is dropped
        if (mem_ready) begin
          state_next = (squash || clear) ? IDLE : HOLD;
        end
      end
      HOLD: begin
        if (clear) begin
          state_next = IDLE;
        end else if (accept) begin
          state_next = issue ? ACCESS : HOLD;
        end else if (out_ready) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= IDLE;
      op_q <= LSU_NONE;
      mem_valid <= 1'b0;
      squash <= 1'b0;
      out_exception <= 1'b0;
    end else begin
      state <= state_next;
      if (accept) begin
        op_q <= in_op;
        mem_valid <= issue;
        out_exception <= misaligned;
      end else if (complete) begin
        mem_valid <= 1'b0;
      end
      squash <= (state == ACCESS) && !mem_ready && (squash || clear);
    end
  end

  // ####################
  // Result register
  // ####################

  always_ff @(posedge clock) begin
    if (accept) begin
      addr_q <= in_addr;
      mem_addr <= in_addr;
      mem_wdata <= st_wdata;
      mem_wstrb <= st_wstrb;
      out_pc <= in_pc;
      out_waddr <= in_waddr;
      out_wdata <= in_wdata;
      out_wren <= in_wren && !misaligned;
      if (ld_misaligned) begin
        out_ecause <= CAUSE_LOAD_MISALIGNED;
      end else if (st_misaligned) begin
        out_ecause <= CAUSE_STORE_MISALIGNED;
      end else begin
        out_ecause <= '0;
      end
      out_etval <= misaligned ? in_addr : '0;
    end else if (complete && op_is_load) begin
      out_wdata <= ld_result;
    end
  end

endmodule

// ==== src/mem_subsystem.sv ====
module mem_subsystem import mem_pkg::*; #(
  parameter int DEPTH_WORDS = 256,
  parameter int WAIT_STATES = 2
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      clear,
  input  logic      in_valid,
  output logic      in_ready,
  input  lsu_op_t   in_op,
  input  addr_t     in_addr,
  input  word_t     in_sdata,
  input  word_t     in_wdata,
  input  reg_addr_t in_waddr,
  input  logic      in_wren,
  input  addr_t     in_pc,
  output logic      out_valid,
  input  logic      out_ready,
  output logic      out_wren,
  output reg_addr_t out_waddr,
  output word_t     out_wdata,
  output logic      out_exception,
  output cause_t    out_ecause,
  output addr_t     out_etval,
  output addr_t     out_pc
);

  // Memory port
  logic    mem_valid;
  logic    mem_ready;
  addr_t   mem_addr;
  word_t   mem_wdata;
  strobe_t mem_wstrb;
  word_t   mem_rdata;

  // Aligner inputs and results
  lsu_op_t op;
  addr_t   op_addr;
  word_t   op_sdata;
  word_t   st_wdata;
  strobe_t st_wstrb;
  logic    st_misaligned;
  word_t   ld_result;
  logic    ld_misaligned;

  memory_control u_control (
    .clock         (clock),
    .reset         (reset),
    .clear         (clear),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_op         (in_op),
    .in_addr       (in_addr),
    .in_sdata      (in_sdata),
    .in_wdata      (in_wdata),
    .in_waddr      (in_waddr),
    .in_wren       (in_wren),
    .in_pc         (in_pc),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_wren      (out_wren),
    .out_waddr     (out_waddr),
    .out_wdata     (out_wdata),
    .out_exception (out_exception),
    .out_ecause    (out_ecause),
    .out_etval     (out_etval),
    .out_pc        (out_pc),
    .mem_valid     (mem_valid),
    .mem_ready     (mem_ready),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_wstrb     (mem_wstrb),
    .op            (op),
    .op_addr       (op_addr),
    .op_sdata      (op_sdata),
    .st_wdata      (st_wdata),
    .st_wstrb      (st_wstrb),
    .st_misaligned (st_misaligned),
    .ld_result     (ld_result),
    .ld_misaligned (ld_misaligned)
  );

  store_align u_store_align (
    .op         (op),
    .addr       (op_addr),
    .sdata      (op_sdata),
    .wdata      (st_wdata),
    .wstrb      (st_wstrb),
    .misaligned (st_misaligned)
  );

  load_align u_load_align (
    .op         (op),
    .addr       (op_addr),
    .rdata      (mem_rdata),
    .result     (ld_result),
    .misaligned (ld_misaligned)
  );

  data_tim #(
    .DEPTH_WORDS (DEPTH_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) u_data_tim (
    .clock     (clock),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

endmodule

// ==== verif/mem_checker.sv ====
module mem_checker import mem_pkg::*; #(
  parameter int DEPTH_WORDS = 256
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      clear,
  input  logic      in_valid,
  input  logic      in_ready,
  input  lsu_op_t   in_op,
  input  addr_t     in_addr,
  input  word_t     in_sdata,
  input  word_t     in_wdata,
  input  reg_addr_t in_waddr,
  input  logic      in_wren,
  input  addr_t     in_pc,
  input  logic      out_valid,
  input  logic      out_ready,
  input  logic      out_wren,
  input  reg_addr_t out_waddr,
  input  word_t     out_wdata,
  input  logic      out_exception,
  input  cause_t    out_ecause,
  input  addr_t     out_etval,
  input  addr_t     out_pc,
  input  logic      finished,
  output int        pending,
  output int        error_count,
  output logic      report_done
);

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [7:0] index;
    lsu_op_t    op;
    logic       wren;
    reg_addr_t  waddr;
    word_t      wdata;
    logic       exception;
    cause_t     cause;
    addr_t      etval;
    addr_t      pc;
  } result_t;

  // Byte-wide copy of the data memory, wrapping like the word index does
  logic [7:0] model [DEPTH_WORDS * 4];

  result_t      expected_q [$];
  logic [106:0] fields;
  logic [106:0] held_fields;
  logic         holding;
  logic         out_of_reset;
  int           accepted;
  int           passed;
  int           flushed;

  assign fields = {out_wren, out_waddr, out_wdata, out_exception,
                   out_ecause, out_etval, out_pc};

  initial begin
    error_count = 0;
    report_done = 1'b0;
    pending = 0;
    holding = 1'b0;
    out_of_reset = 1'b0;
    accepted = 0;
    passed = 0;
    flushed = 0;
  end

  function automatic int lane(addr_t addr);
    return int'(addr % (DEPTH_WORDS * 4));
  endfunction

  function automatic string op_name(lsu_op_t op);
    return op.name();
  endfunction

  function automatic result_t as_exception(result_t r, cause_t cause, addr_t addr);
    r.exception = 1'b1;
    r.cause = cause;
    r.etval = addr;
    r.wren = 1'b0;
    return r;
  endfunction

  function automatic int differs(string where, string name, word_t got, word_t want);
    if (got !== want) begin
      $display("FAILED %s: %s got %h, expected %h", where, name, got, want);
      return 1;
    end
    return 0;
  endfunction

  // ####################
  // Reference model
  // ####################

  task automatic predict();
    result_t r;
    int      b;
    r = '0;
    r.index = accepted[7:0];
    r.op = in_op;
    r.wren = in_wren;
    r.waddr = in_waddr;
    r.wdata = in_wdata;
    r.pc = in_pc;
    b = lane(in_addr);
    case (in_op)
      LSU_LB: begin
        r.wdata = {{24{model[b][7]}}, model[b]};
      end
      LSU_LBU: begin
        r.wdata = {24'b0, model[b]};
      end
      LSU_LH, LSU_LHU: begin
        if (in_addr[0]) begin
          r = as_exception(r, CAUSE_LOAD_MISALIGNED, in_addr);
        end else if (in_op == LSU_LH) begin
          r.wdata = {{16{model[b + 1][7]}}, model[b + 1], model[b]};
        end else begin
          r.wdata = {16'b0, model[b + 1], model[b]};
        end
      end
      LSU_LW: begin
        if (in_addr[1:0] != 2'b00) begin
          r = as_exception(r, CAUSE_LOAD_MISALIGNED, in_addr);
        end else begin
          r.wdata = {model[b + 3], model[b + 2], model[b + 1], model[b]};
        end
      end
      LSU_SB: begin
        model[b] = in_sdata[7:0];
      end
      LSU_SH: begin
        if (in_addr[0]) begin
          r = as_exception(r, CAUSE_STORE_MISALIGNED, in_addr);
        end else begin
          model[b] = in_sdata[7:0];
          model[b + 1] = in_sdata[15:8];
        end
      end
      LSU_SW: begin
        if (in_addr[1:0] != 2'b00) begin
          r = as_exception(r, CAUSE_STORE_MISALIGNED, in_addr);
        end else begin
          for (int k = 0; k < 4; k++) begin
            model[b + k] = in_sdata[8 * k +: 8];
          end
        end
      end
      default: begin
      end
    endcase
    expected_q.push_back(r);
    accepted++;
  endtask

  task automatic compare_result(result_t e);
    int    bad;
    string where;
    bad = 0;
    where = $sformatf("test %0d", e.index);
    bad += differs(where, "out_exception", out_exception, e.exception);
    bad += differs(where, "out_wren", out_wren, e.wren);
    bad += differs(where, "out_waddr", out_waddr, e.waddr);
    bad += differs(where, "out_pc", out_pc, e.pc);
    if (e.exception) begin
      bad += differs(where, "out_ecause", out_ecause, e.cause);
      bad += differs(where, "out_etval", out_etval, e.etval);
    end else begin
      bad += differs(where, "out_wdata", out_wdata, e.wdata);
    end
    if (bad == 0) begin
      passed++;
      $display("test %0d %s passed", e.index, op_name(e.op));
    end else begin
      error_count += bad;
      $display("test %0d %s failed", e.index, op_name(e.op));
    end
  endtask

  // ####################
  // Port monitor
  // ####################

  always @(posedge clock) begin
    result_t e;
    if (!reset) begin
      expected_q.delete();
      holding = 1'b0;
      out_of_reset = 1'b0;
    end else begin
      if (!out_of_reset) begin
        out_of_reset = 1'b1;
        error_count += differs("after reset", "out_valid", out_valid, 1'b0);
        error_count += differs("after reset", "out_exception", out_exception, 1'b0);
        error_count += differs("after reset", "in_ready", in_ready, 1'b1);
      end

      // A result left waiting must stay put until writeback takes it
      if (holding) begin
        if (!out_valid) begin
          $display("out_valid dropped while a result was waiting for out_ready");
          error_count++;
        end else if (fields !== held_fields) begin
          $display("a held result changed while out_ready was low");
          error_count++;
        end
      end
      holding = out_valid && !out_ready && !clear;
      held_fields = fields;

      if (out_valid && out_ready && !clear) begin
        if (expected_q.size() == 0) begin
          $display("a result came out with no instruction pending");
          error_count++;
        end else begin
          e = expected_q.pop_front();
          compare_result(e);
        end
      end

      // Whatever is in flight at a clear edge must never reach writeback
      if (clear) begin
        if (in_ready) begin
          $display("in_ready was high while clear was asserted");
          error_count++;
        end
        while (expected_q.size() > 0) begin
          e = expected_q.pop_front();
          flushed++;
          $display("test %0d %s flushed by clear", e.index, op_name(e.op));
        end
      end

      if (in_valid && in_ready) begin
        predict();
      end

      if (finished && !report_done) begin
        while (expected_q.size() > 0) begin
          e = expected_q.pop_front();
          error_count++;
          $display("test %0d %s never produced a result", e.index, op_name(e.op));
        end
        $display("%0d tests passed, %0d flushed, %0d failures", passed, flushed, error_count);
        report_done = 1'b1;
      end
    end
    pending = expected_q.size();
  end

endmodule

// ==== verif/mem_subsystem_tb.sv ====
module mem_subsystem_tb import mem_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH_WORDS = 256;
  localparam int WAIT_STATES = 2;
  localparam int NUM_TESTS = 32;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * (WAIT_STATES + 8);

  // Clear delays in cycles after acceptance, one lands in ACCESS and one in HOLD
  localparam int CLEAR_IN_ACCESS = 1;
  localparam int CLEAR_IN_HOLD = WAIT_STATES + 3;

  // A zero store value in the table draws a random word instead
  localparam word_t RANDOM_DATA = 32'h0;

  logic      clock;
  logic      reset;
  logic      clear;
  logic      in_valid;
  logic      in_ready;
  lsu_op_t   in_op;
  addr_t     in_addr;
  word_t     in_sdata;
  word_t     in_wdata;
  reg_addr_t in_waddr;
  logic      in_wren;
  addr_t     in_pc;
  logic      out_valid;
  logic      out_ready;
  logic      out_wren;
  reg_addr_t out_waddr;
  word_t     out_wdata;
  logic      out_exception;
  cause_t    out_ecause;
  addr_t     out_etval;
  addr_t     out_pc;

  logic finished;
  logic report_done;
  int   pending;
  int   error_count;
  int   entries;
  int   cycles = 0;

  word_t rng_state = 32'hab45;

  // Stimulus table, one column per field
  lsu_op_t   tab_op [NUM_TESTS];
  addr_t     tab_addr [NUM_TESTS];
  word_t     tab_sdata [NUM_TESTS];
  word_t     tab_wdata [NUM_TESTS];
  reg_addr_t tab_waddr [NUM_TESTS];
  logic      tab_wren [NUM_TESTS];
  int        tab_clear [NUM_TESTS];

  mem_subsystem #(
    .DEPTH_WORDS (DEPTH_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) UUT (.*);

  mem_checker #(
    .DEPTH_WORDS (DEPTH_WORDS)
  ) u_checker (.*);

  initial begin
    clock = 1'b0;
  end

  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout, the run was stopped after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic word_t xorshift32(word_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Writeback is ready about three cycles in four
  function automatic logic ready_pattern();
    word_t r;
    r = next_random();
    return r[1:0] != 2'b00;
  endfunction

  task automatic add_entry(input lsu_op_t op, input addr_t addr, input word_t sdata,
                           input word_t wdata, input reg_addr_t waddr, input logic wren,
                           input int clear_after);
    tab_op[entries] = op;
    tab_addr[entries] = addr;
    tab_sdata[entries] = sdata;
    tab_wdata[entries] = wdata;
    tab_waddr[entries] = waddr;
    tab_wren[entries] = wren;
    tab_clear[entries] = clear_after;
    entries++;
  endtask

  task automatic build_table();
    entries = 0;
    // ####################
    // Words, then byte and halfword lanes
    // ####################
    add_entry(LSU_SW, 32'h100, RANDOM_DATA, 32'h0, 5'd0, 1'b0, 0);
    add_entry(LSU_SW, 32'h104, RANDOM_DATA, 32'h0, 5'd0, 1'b0, 0);
    add_entry(LSU_SW, 32'h108, 32'h8081_f27f, 32'h0, 5'd0, 1'b0, 0);
    add_entry(LSU_SW, 32'h10c, 32'h1234_5678, 32'h0, 5'd0, 1'b0, 0);
    add_entry(LSU_LW, 32'h100, 32'h0, 32'h0, 5'd5, 1'b1, 0);
    add_entry(LSU_LW, 32'h104, 32'h0, 32'h0, 5'd6, 1'b1, 0);
    add_entry(LSU_SB, 32'h109, 32'h0000_00a5, 32'h0, 5'd0, 1'b0, 0);
    add_entry(LSU_SH, 32'h10e, 32'h0000_beef, 32'h0, 5'd0, 1'b0, 0);
    add_entry(LSU_LB, 32'h108, 32'h0, 32'h0, 5'd7, 1'b1, 0);
    add_entry(LSU_LB, 32'h109, 32'h0, 32'h0, 5'd8, 1'b1, 0);
    add_entry(LSU_LBU, 32'h109, 32'h0, 32'h0, 5'd9, 1'b1, 0);
    add_entry(LSU_LH, 32'h10a, 32'h0, 32'h0, 5'd10, 1'b1, 0);
    add_entry(LSU_LHU, 32'h10a, 32'h0, 32'h0, 5'd11, 1'b1, 0);
    add_entry(LSU_LHU, 32'h10c, 32'h0, 32'h0, 5'd12, 1'b1, 0);
    add_entry(LSU_LH, 32'h10e, 32'h0, 32'h0, 5'd13, 1'b1, 0);
    add_entry(LSU_LW, 32'h108, 32'h0, 32'h0, 5'd14, 1'b1, 0);
    // ####################
    // Pass-through and exceptions
    // ####################
    add_entry(LSU_NONE, 32'h0, 32'h0, 32'hdead_beef, 5'd15, 1'b1, 0);
    add_entry(LSU_NONE, 32'h0, 32'h0, 32'h0000_0001, 5'd0, 1'b0, 0);
    add_entry(LSU_LBU, 32'h10f, 32'h0, 32'h0, 5'd16, 1'b1, 0);
    add_entry(LSU_NONE, 32'h0, 32'h0, 32'h7654_3210, 5'd31, 1'b1, 0);
    add_entry(LSU_LH, 32'h101, 32'h0, 32'h0, 5'd17, 1'b1, 0);
    add_entry(LSU_LW, 32'h102, 32'h0, 32'h0, 5'd17, 1'b1, 0);
    add_entry(LSU_SH, 32'h103, 32'h0000_ffff, 32'h0, 5'd0, 1'b0, 0);
    add_entry(LSU_SW, 32'h105, RANDOM_DATA, 32'h0, 5'd0, 1'b0, 0);
    add_entry(LSU_LW, 32'h104, 32'h0, 32'h0, 5'd18, 1'b1, 0);
    add_entry(LSU_LW, 32'h100, 32'h0, 32'h0, 5'd19, 1'b1, 0);
    // ####################
    // Clear
    // ####################
    add_entry(LSU_SW, 32'h110, 32'h0bad_cafe, 32'h0, 5'd0, 1'b0, CLEAR_IN_ACCESS);
    add_entry(LSU_LW, 32'h110, 32'h0, 32'h0, 5'd20, 1'b1, CLEAR_IN_HOLD);
    add_entry(LSU_NONE, 32'h0, 32'h0, 32'h1111_2222, 5'd21, 1'b1, CLEAR_IN_ACCESS);
    add_entry(LSU_LW, 32'h110, 32'h0, 32'h0, 5'd22, 1'b1, 0);
    add_entry(LSU_SB, 32'h113, RANDOM_DATA, 32'h0, 5'd0, 1'b0, 0);
    add_entry(LSU_LB, 32'h113, 32'h0, 32'h0, 5'd23, 1'b1, 0);
  endtask

  // Writeback is held off until the clear so the result cannot escape first
  task automatic flush_after(input int delay);
    @(negedge clock);
    in_valid = 1'b0;
    out_ready = 1'b0;
    repeat (delay - 1) @(negedge clock);
    clear = 1'b1;
    repeat (2) @(negedge clock);
    clear = 1'b0;
    out_ready = ready_pattern();
  endtask

  task automatic apply_entry(input int i);
    logic taken;
    @(negedge clock);
    in_valid = 1'b1;
    in_op = tab_op[i];
    in_addr = tab_addr[i];
    in_sdata = (tab_sdata[i] == RANDOM_DATA) ? next_random() : tab_sdata[i];
    in_wdata = tab_wdata[i];
    in_waddr = tab_waddr[i];
    in_wren = tab_wren[i];
    in_pc = 32'h0000_1000 + 32'(4 * i);
    out_ready = ready_pattern();
    taken = 1'b0;
    while (!taken) begin
      @(posedge clock);
      taken = in_ready;
      if (!taken) begin
        @(negedge clock);
        out_ready = ready_pattern();
      end
    end
    if (tab_clear[i] > 0) begin
      flush_after(tab_clear[i]);
    end
  endtask

  initial begin
    reset = 1'b0;
    clear = 1'b0;
    in_valid = 1'b0;
    in_op = LSU_NONE;
    in_addr = '0;
    in_sdata = '0;
    in_wdata = '0;
    in_waddr = '0;
    in_wren = 1'b0;
    in_pc = '0;
    out_ready = 1'b0;
    finished = 1'b0;
    build_table();
    repeat (2) @(negedge clock);
    reset = 1'b1;

    for (int i = 0; i < NUM_TESTS; i++) begin
      apply_entry(i);
    end
    @(negedge clock);
    in_valid = 1'b0;
    while (pending != 0) begin
      out_ready = ready_pattern();
      @(negedge clock);
    end

    finished = 1'b1;
    while (!report_done) begin
      @(negedge clock);
    end
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== mem_stage.f ====
src/mem_pkg.sv
src/store_align.sv
src/load_align.sv
src/data_tim.sv
src/memory_control.sv
src/mem_subsystem.sv
verif/mem_checker.sv
verif/mem_subsystem_tb.sv
